//--- conv_code_pkg.sv
/* Code and symbol definitions shared by the encoder chain.
   Defaults give the K=7 rate-1/2 mother code punctured to rate 3/4 */
package conv_code_pkg;

  //////////////////////////////////////////////////
  // Code defaults, overridable from the top level
  //////////////////////////////////////////////////
  localparam int         DEF_K            = 7;
  localparam logic [6:0] DEF_G_UPPER      = 7'b1011011;  // Tap 0 is the newest bit
  localparam logic [6:0] DEF_G_LOWER      = 7'b1111001;
  localparam int         DEF_PUNCT_LEN    = 6;           // Coded bits per pattern
  // Consumed from the top bit down, one bit per serialized coded bit
  localparam logic [5:0] DEF_PUNCT_VECTOR = 6'b110110;

  // Datapath widths
  localparam int DATA_W   = 32;  // Input word
  localparam int SAMPLE_W = 32;  // Output sample, one LUT entry

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // One input bit gives one pair, serialized upper first
  typedef struct packed {
    logic upper;
    logic lower;
  } coded_pair_t;

  // QPSK symbol, also the LUT address
  typedef logic [1:0] symbol_t;

  typedef enum logic [1:0] {
    ST_LOAD   = 2'd0,  // No word since the last clear
    ST_WARMUP = 2'd1,  // Filling the shift register
    ST_RUN    = 2'd2   // Every shift produces a pair
  } enc_state_e;

endpackage

//--- ctrl_pkg.sv
/* Settings bus addresses and the configuration types decoded from it.
   Only the low bits of a data word are used for flags and LUT address */
package ctrl_pkg;

  // Settings addresses, matched on the strobe
  typedef enum logic [7:0] {
    SR_USER_RESET   = 8'd131,  // Level, clears the pipeline while set
    SR_REVERSE_BITS = 8'd135,  // Shift words LSB first
    SR_LUT_ADDR     = 8'd139,  // Held LUT write address
    SR_LUT_DATA     = 8'd140,  // Writes the LUT at the held address
    SR_SWAP_IQ      = 8'd141   // First bit of a symbol goes to the LSB
  } sr_addr_e;

  typedef struct packed {
    logic        stb;
    logic [7:0]  addr;
    logic [31:0] data;
  } set_bus_t;

  typedef struct packed {
    logic user_reset;
    logic reverse_bits;
    logic swap_iq;
  } cfg_t;

  // One-cycle write into the symbol LUT
  typedef struct packed {
    logic        en;
    logic [1:0]  addr;
    logic [31:0] data;
  } lut_wr_t;

endpackage

//--- conv_cfg_regs.sv
/* Settings bus decoder. Flags follow a write one cycle after the strobe.
   A LUT data write pulses o_lut_wr.en once, with the address held before */
`timescale 1ns/1ps

module conv_cfg_regs
  import ctrl_pkg::*;
(
  input  logic     ce_clk,
  input  logic     i_reset,
  input  set_bus_t i_set,
  output cfg_t     o_cfg,
  output lut_wr_t  o_lut_wr
);

  sr_addr_e    addr;
  logic        lut_data_wr;   // LUT data write on this strobe
  logic [1:0]  lut_addr;      // Last address written to SR_LUT_ADDR
  logic        lut_wr_en;
  logic [1:0]  lut_wr_addr;
  logic [31:0] lut_wr_data;

  assign addr        = sr_addr_e'(i_set.addr);
  assign lut_data_wr = i_set.stb && (addr == SR_LUT_DATA);

  always_ff @(posedge ce_clk) begin
    if (i_reset) begin
      o_cfg     <= '0;
      lut_addr  <= '0;
      lut_wr_en <= 1'b0;
    end else begin
      lut_wr_en <= lut_data_wr;  // Single cycle pulse
      if (i_set.stb) begin
        case (addr)
          SR_USER_RESET:   o_cfg.user_reset   <= i_set.data[0];
          SR_REVERSE_BITS: o_cfg.reverse_bits <= i_set.data[0];
          SR_SWAP_IQ:      o_cfg.swap_iq      <= i_set.data[0];
          SR_LUT_ADDR:     lut_addr           <= i_set.data[1:0];
          default: ;
        endcase
      end
    end
  end

  // Write payload, captured with the pulse
  always_ff @(posedge ce_clk) begin
    if (lut_data_wr) begin
      lut_wr_addr <= lut_addr;
      lut_wr_data <= i_set.data;
    end
  end

  assign o_lut_wr = '{en: lut_wr_en, addr: lut_wr_addr, data: lut_wr_data};

endmodule

//--- conv_encoder.sv
/* Rate-1/2 convolutional encoder, K of 3 or more. Words shift MSB first
   (LSB first with reverse_bits); the first K-1 bits after a clear give no pair */
`timescale 1ns/1ps

module conv_encoder
  import conv_code_pkg::*;
  import ctrl_pkg::*;
#(
  parameter int           K       = DEF_K,
  parameter logic [K-1:0] G_UPPER = DEF_G_UPPER,
  parameter logic [K-1:0] G_LOWER = DEF_G_LOWER
) (
  input  logic              ce_clk,
  input  logic              i_reset,
  input  cfg_t              i_cfg,
  input  logic [DATA_W-1:0] i_word_data,
  input  logic              i_word_valid,
  output logic              o_word_ready,
  output coded_pair_t       o_pair,
  output logic              o_pair_valid,
  input  logic              i_pair_ready
);

  localparam int CNT_W  = $clog2(DATA_W);
  localparam int WARM_W = $clog2(K);

  logic              clear;
  enc_state_e        state;
  logic [DATA_W-1:0] word_rev;
  logic [DATA_W-1:0] buf_q;       // Next bit to shift sits at the top
  logic              buf_full;
  logic [CNT_W-1:0]  shift_cnt;   // Bits of the current word already shifted
  logic [WARM_W-1:0] warm_cnt;
  logic [K-1:0]      sreg;        // Newest bit at position 0
  logic              word_ready_q;
  logic              advance;
  logic              take_word;

  assign clear    = i_reset | i_cfg.user_reset;
  assign word_rev = {<<{i_word_data}};

  // Shift while the held pair is taken, or while there is none to hold
  assign advance = buf_full & (i_pair_ready | ~o_pair_valid);

  // Armed after bit 30, open only while the last bit actually moves out
  assign o_word_ready = word_ready_q & (~buf_full | advance);
  assign take_word    = i_word_valid & o_word_ready;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (clear) begin
      state        <= ST_LOAD;
      buf_full     <= 1'b0;
      shift_cnt    <= '0;
      warm_cnt     <= '0;
      word_ready_q <= 1'b0;
      o_pair_valid <= 1'b0;
    end else begin
      if (advance) begin
        o_pair_valid <= (state == ST_RUN);  // Pair of the bit entering now
        shift_cnt    <= shift_cnt + 1'b1;
        if (shift_cnt == CNT_W'(DATA_W - 1)) buf_full <= 1'b0;
        if (shift_cnt == CNT_W'(DATA_W - 2)) word_ready_q <= 1'b1;
      end else if (i_pair_ready) begin
        o_pair_valid <= 1'b0;  // Taken, nothing new behind it
      end

      if (!buf_full) word_ready_q <= 1'b1;

      if (take_word) begin
        word_ready_q <= 1'b0;
        buf_full     <= 1'b1;
        shift_cnt    <= '0;
      end

      case (state)
        ST_LOAD: begin
          if (take_word) state <= ST_WARMUP;
        end
        ST_WARMUP: begin
          if (advance) begin
            if (warm_cnt == WARM_W'(K - 2)) state <= ST_RUN;
            else warm_cnt <= warm_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Word buffer and code shift register, contents kept across a pause
  always_ff @(posedge ce_clk) begin
    if (take_word) buf_q <= i_cfg.reverse_bits ? word_rev : i_word_data;
    else if (advance) buf_q <= buf_q << 1;
    if (advance) sreg <= {sreg[K-2:0], buf_q[DATA_W-1]};
  end

  // Coded bits, parity of the tapped register bits
  assign o_pair.upper = ^(sreg & G_UPPER);
  assign o_pair.lower = ^(sreg & G_LOWER);

endmodule

//--- puncturer.sv
/* Serializes coded pairs upper first and drops bits where the pattern is 0.
   PUNCT_LEN must be even so that a pattern covers whole pairs */
`timescale 1ns/1ps

module puncturer
  import conv_code_pkg::*;
  import ctrl_pkg::*;
#(
  parameter int                   PUNCT_LEN    = DEF_PUNCT_LEN,
  parameter logic [PUNCT_LEN-1:0] PUNCT_VECTOR = DEF_PUNCT_VECTOR
) (
  input  logic        ce_clk,
  input  logic        i_reset,
  input  cfg_t        i_cfg,
  input  coded_pair_t i_pair,
  input  logic        i_pair_valid,
  output logic        o_pair_ready,
  output logic        o_bit,
  output logic        o_bit_valid,
  input  logic        i_bit_ready
);

  localparam int IDX_W = $clog2(PUNCT_LEN);

  logic             clear;
  logic             sel_lower;  // Upper bit of the pair already handled
  logic             cur_bit;
  logic             keep;
  logic             out_free;
  logic             step;       // One coded bit consumed
  logic [IDX_W-1:0] idx;

  assign clear    = i_reset | i_cfg.user_reset;
  assign cur_bit  = sel_lower ? i_pair.lower : i_pair.upper;
  assign keep     = PUNCT_VECTOR[idx];
  assign out_free = ~o_bit_valid | i_bit_ready;

  // A dropped bit needs no room in the output register
  assign step         = i_pair_valid & (~keep | out_free);
  assign o_pair_ready = sel_lower & (~keep | out_free);  // Pair leaves with its lower bit

  always_ff @(posedge ce_clk) begin
    if (clear) begin
      idx         <= IDX_W'(PUNCT_LEN - 1);
      sel_lower   <= 1'b0;
      o_bit_valid <= 1'b0;
    end else begin
      if (step) begin
        sel_lower <= ~sel_lower;
        idx       <= (idx == '0) ? IDX_W'(PUNCT_LEN - 1) : idx - 1'b1;
      end
      if (step && keep) o_bit_valid <= 1'b1;
      else if (i_bit_ready) o_bit_valid <= 1'b0;
    end
  end

  // Surviving bit
  always_ff @(posedge ce_clk) begin
    if (step && keep) o_bit <= cur_bit;
  end

endmodule

//--- symbol_mapper.sv
/* QPSK mapper with a 4-entry sample LUT, kept through a user reset.
   A sample leaves two cycles after its second bit when the output is free */
`timescale 1ns/1ps

module symbol_mapper
  import conv_code_pkg::*;
  import ctrl_pkg::*;
(
  input  logic                ce_clk,
  input  logic                i_reset,
  input  cfg_t                i_cfg,
  input  lut_wr_t             i_lut_wr,
  input  logic                i_bit,
  input  logic                i_bit_valid,
  output logic                o_bit_ready,
  output logic [SAMPLE_W-1:0] o_sample_data,
  output logic                o_sample_valid,
  input  logic                i_sample_ready
);

  logic                clear;
  logic                have_first;   // First bit of a symbol is held
  logic                first_bit;
  logic                bit_take;
  logic                second_take;  // Symbol complete, LUT read issued
  symbol_t             sym;
  logic                out_free;
  logic                rd_free;
  logic                rd_valid;
  logic [SAMPLE_W-1:0] rd_data;
  logic [SAMPLE_W-1:0] lut [4];

  assign clear = i_reset | i_cfg.user_reset;

  // Two-deep output, LUT read stage then sample register
  assign out_free = ~o_sample_valid | i_sample_ready;
  assign rd_free  = ~rd_valid | out_free;

  assign o_bit_ready = ~have_first | rd_free;
  assign bit_take    = i_bit_valid & o_bit_ready;
  assign second_take = bit_take & have_first;
  assign sym = i_cfg.swap_iq ? {i_bit, first_bit} : {first_bit, i_bit};

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (clear) begin
      have_first     <= 1'b0;
      rd_valid       <= 1'b0;
      o_sample_valid <= 1'b0;
    end else begin
      if (bit_take) have_first <= ~have_first;
      if (rd_free) rd_valid <= second_take;
      if (out_free) o_sample_valid <= rd_valid;
    end
  end

  // Symbol LUT with registered read
  always_ff @(posedge ce_clk) begin
    if (i_lut_wr.en) lut[i_lut_wr.addr] <= i_lut_wr.data;
    if (second_take) rd_data <= lut[sym];
  end

  always_ff @(posedge ce_clk) begin
    if (bit_take && !have_first) first_bit <= i_bit;
    if (out_free && rd_valid) o_sample_data <= rd_data;  // Held while stalled
  end

endmodule

//--- conv_qpsk_top.sv
/* Rate-3/4 convolutional encoder with QPSK mapping. Load the LUT before
   streaming; all stages clear on i_reset or while user reset is set */
`timescale 1ns/1ps

module conv_qpsk_top
  import conv_code_pkg::*;
  import ctrl_pkg::*;
#(
  parameter int                   K            = DEF_K,
  parameter logic [K-1:0]         G_UPPER      = DEF_G_UPPER,
  parameter logic [K-1:0]         G_LOWER      = DEF_G_LOWER,
  parameter int                   PUNCT_LEN    = DEF_PUNCT_LEN,
  parameter logic [PUNCT_LEN-1:0] PUNCT_VECTOR = DEF_PUNCT_VECTOR
) (
  input  logic                ce_clk,
  input  logic                i_reset,
  input  set_bus_t            i_set,
  input  logic [DATA_W-1:0]   i_word_data,
  input  logic                i_word_valid,
  output logic                o_word_ready,
  output logic [SAMPLE_W-1:0] o_sample_data,
  output logic                o_sample_valid,
  input  logic                i_sample_ready
);

  cfg_t        cfg;
  lut_wr_t     lut_wr;
  coded_pair_t pair;
  logic        pair_valid;
  logic        pair_ready;
  logic        punct_bit;
  logic        punct_bit_valid;
  logic        punct_bit_ready;

  //////////////////////////////////////////////////
  // Settings
  //////////////////////////////////////////////////
  conv_cfg_regs cfg_regs0 (
    .ce_clk   (ce_clk),
    .i_reset  (i_reset),
    .i_set    (i_set),
    .o_cfg    (cfg),
    .o_lut_wr (lut_wr)
  );

  //////////////////////////////////////////////////
  // Encode, puncture, map
  //////////////////////////////////////////////////
  conv_encoder #(
    .K       (K),
    .G_UPPER (G_UPPER),
    .G_LOWER (G_LOWER)
  ) encoder0 (
    .ce_clk       (ce_clk),
    .i_reset      (i_reset),
    .i_cfg        (cfg),
    .i_word_data  (i_word_data),
    .i_word_valid (i_word_valid),
    .o_word_ready (o_word_ready),
    .o_pair       (pair),
    .o_pair_valid (pair_valid),
    .i_pair_ready (pair_ready)
  );

  puncturer #(
    .PUNCT_LEN    (PUNCT_LEN),
    .PUNCT_VECTOR (PUNCT_VECTOR)
  ) punct0 (
    .ce_clk       (ce_clk),
    .i_reset      (i_reset),
    .i_cfg        (cfg),
    .i_pair       (pair),
    .i_pair_valid (pair_valid),
    .o_pair_ready (pair_ready),
    .o_bit        (punct_bit),
    .o_bit_valid  (punct_bit_valid),
    .i_bit_ready  (punct_bit_ready)
  );

  symbol_mapper mapper0 (
    .ce_clk         (ce_clk),
    .i_reset        (i_reset),
    .i_cfg          (cfg),
    .i_lut_wr       (lut_wr),
    .i_bit          (punct_bit),
    .i_bit_valid    (punct_bit_valid),
    .o_bit_ready    (punct_bit_ready),
    .o_sample_data  (o_sample_data),
    .o_sample_valid (o_sample_valid),
    .i_sample_ready (i_sample_ready)
  );

endmodule

//--- conv_qpsk_chk.sv
/* Protocol checks on the top-level ports, bound into conv_qpsk_top.
   fail_cnt counts failed checks for the testbench to read */
`timescale 1ns/1ps

module conv_qpsk_chk
  import conv_code_pkg::*;
(
  input logic                ce_clk,
  input logic                i_reset,
  input logic                o_word_ready,
  input logic [SAMPLE_W-1:0] o_sample_data,
  input logic                o_sample_valid,
  input logic                i_sample_ready
);

  int fail_cnt = 0;

  // Outputs idle during reset and the cycle after
  quiet_after_reset: assert property (@(posedge ce_clk)
    i_reset |=> (!o_word_ready && !o_sample_valid))
    else begin
      $error("word ready or sample valid high in or right after reset");
      fail_cnt++;
    end

  hold_under_stall: assert property (@(posedge ce_clk) disable iff (i_reset)
    (o_sample_valid && !i_sample_ready) |=> (o_sample_valid && $stable(o_sample_data)))
    else begin
      $error("stalled sample dropped or changed");
      fail_cnt++;
    end

  known_sample: assert property (@(posedge ce_clk) disable iff (i_reset)
    o_sample_valid |-> !$isunknown(o_sample_data))
    else begin
      $error("valid sample has unknown bits");
      fail_cnt++;
    end

endmodule

bind conv_qpsk_top conv_qpsk_chk chk0 (.*);

//--- conv_qpsk_tb.sv
/* Testbench for the encoder and mapper chain with default code parameters.
   Words and output stalls come from one LFSR; the LUT holds QPSK samples */
`timescale 1ns/1ps

module conv_qpsk_tb
  import conv_code_pkg::*;
  import ctrl_pkg::*;
();

  localparam int         K       = DEF_K;
  localparam logic [6:0] G_UP    = DEF_G_UPPER;
  localparam logic [6:0] G_LO    = DEF_G_LOWER;
  localparam int         PLEN    = DEF_PUNCT_LEN;
  localparam logic [5:0] PVEC    = DEF_PUNCT_VECTOR;
  localparam int         N_WORDS = 12;
  localparam logic [SAMPLE_W-1:0] LUT_VALS [4] = '{32'h5A82_5A82, 32'h5A82_A57E,
                                                   32'hA57E_5A82, 32'hA57E_A57E};

  logic                ce_clk = 1'b0;
  logic                i_reset;
  set_bus_t            i_set;
  logic [DATA_W-1:0]   i_word_data;
  logic                i_word_valid;
  logic                o_word_ready;
  logic [SAMPLE_W-1:0] o_sample_data;
  logic                o_sample_valid;
  logic                i_sample_ready;

  logic [31:0]         lfsr = 32'h29200c69;
  logic [DATA_W-1:0]   words [N_WORDS];
  logic [SAMPLE_W-1:0] exp_q [$];
  logic [SAMPLE_W-1:0] exp_head;      // Head of exp_q for the assertion
  int                  exp_left = 0;
  int                  rcv_count = 0;

  conv_qpsk_top dut0 (.*);

  always #2 ce_clk = ~ce_clk;

  function automatic logic next_rand_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // Taps 32, 22, 2, 1
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic void refresh_head();
    exp_left = exp_q.size();
    exp_head = (exp_left > 0) ? exp_q[0] : 'x;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout at %0t: %s", $time, what);
    $display("test failed");
    $fatal(1, "wait timed out");
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  task automatic build_expected(input int first, input int count, input logic rev,
                                input logic swap, output int n_sym);
    logic         stream [$];
    logic         kept [$];
    logic [K-1:0] win;
    logic [1:0]   coded;
    int           m;
    m = 0;
    for (int w = first; w < first + count; w++)
      for (int i = 0; i < DATA_W; i++)
        stream.push_back(rev ? words[w][i] : words[w][DATA_W-1-i]);
    // No pair for the first K-1 bits after a clear
    for (int n = K - 1; n < stream.size(); n++) begin
      for (int j = 0; j < K; j++) win[j] = stream[n-j];  // Newest bit at tap 0
      coded = {^(win & G_UP), ^(win & G_LO)};
      for (int c = 1; c >= 0; c--) begin
        if (PVEC[PLEN - 1 - (m % PLEN)]) kept.push_back(coded[c]);
        m++;
      end
    end
    for (int t = 0; t + 1 < kept.size(); t += 2)
      exp_q.push_back(LUT_VALS[swap ? {kept[t+1], kept[t]} : {kept[t], kept[t+1]}]);
    n_sym = kept.size() / 2;
    refresh_head();
  endtask

  //////////////////////////////////////////////////
  // Drivers
  //////////////////////////////////////////////////
  task automatic write_setting(input sr_addr_e sel, input logic [31:0] data);
    i_set = '{stb: 1'b1, addr: sel, data: data};
    @(posedge ce_clk);
    #1;
    i_set = '0;
  endtask

  task automatic send_word(input logic [DATA_W-1:0] w);
    int wait_cnt;
    wait_cnt = 0;
    i_word_data  = w;
    i_word_valid = 1'b1;
    @(posedge ce_clk);
    while (!o_word_ready) begin
      wait_cnt++;
      if (wait_cnt > 500) abort_on_timeout("input word was never accepted");
      @(posedge ce_clk);
    end
    #1;
    i_word_valid = 1'b0;
  endtask

  task automatic run_phase(input int first, input int count, input logic rev,
                           input logic swap);
    int n_sym;
    int want;
    int wait_cnt;
    build_expected(first, count, rev, swap, n_sym);
    rcv_count = 0;
    wait_cnt  = 0;
    for (int w = first; w < first + count; w++) send_word(words[w]);
    while (exp_q.size() != 0) begin
      wait_cnt++;
      if (wait_cnt > 4000) abort_on_timeout("expected samples never came out");
      @(posedge ce_clk);
      #1;
    end
    repeat (16) @(posedge ce_clk);  // Room for any extra sample
    #1;
    // Count from the code rate after warm-up and two bits per symbol
    want = ((count * DATA_W - (K - 1)) * 2 * $countones(PVEC) / PLEN) / 2;
    assert (rcv_count == n_sym && n_sym == want) else begin
      $display("MISMATCH at %0t: %0d samples, model %0d, rate gives %0d", $time,
               rcv_count, n_sym, want);
      $display("test failed");
      $fatal(1, "sample count");
    end
  endtask

  always @(posedge ce_clk) begin
    #1;
    i_sample_ready = next_rand_bit() | next_rand_bit();  // Ready three cycles in four
  end

  // Retire accepted samples from the expected queue
  always @(posedge ce_clk) begin
    if (!i_reset && o_sample_valid && i_sample_ready) begin
      if (exp_q.size() > 0) void'(exp_q.pop_front());
      rcv_count++;
      refresh_head();
    end
  end

  property sample_matches;
    @(posedge ce_clk) disable iff (i_reset)
      (o_sample_valid && i_sample_ready && exp_left > 0) |-> (o_sample_data == exp_head);
  endproperty

  check_sample: assert property (sample_matches) else begin
    $display("MISMATCH at %0t: sample %h, expected %h, %0d pending", $time,
             $sampled(o_sample_data), $sampled(exp_head), $sampled(exp_left));
    $display("test failed");
    $fatal(1, "sample value");
  end

  always @(posedge ce_clk) begin
    if (dut0.chk0.fail_cnt != 0) begin
      $display("test failed");
      $fatal(1, "bound protocol checker reported an error");
    end
  end

  initial begin
    i_reset        = 1'b1;
    i_set          = '0;
    i_word_data    = '0;
    i_word_valid   = 1'b0;
    i_sample_ready = 1'b0;
    for (int w = 0; w < N_WORDS; w++)
      for (int i = 0; i < DATA_W; i++) words[w][i] = next_rand_bit();
    repeat (5) @(posedge ce_clk);
    #1;
    i_reset = 1'b0;
    for (int a = 0; a < 4; a++) begin
      write_setting(SR_LUT_ADDR, a);
      write_setting(SR_LUT_DATA, LUT_VALS[a]);
    end
    run_phase(0, 6, 1'b0, 1'b0);
    write_setting(SR_REVERSE_BITS, 1);
    write_setting(SR_USER_RESET, 1);
    write_setting(SR_USER_RESET, 0);
    run_phase(6, 3, 1'b1, 1'b0);
    write_setting(SR_REVERSE_BITS, 0);
    write_setting(SR_SWAP_IQ, 1);
    write_setting(SR_USER_RESET, 1);
    write_setting(SR_USER_RESET, 0);
    run_phase(9, 3, 1'b0, 1'b1);
    if (dut0.chk0.fail_cnt != 0) begin
      $display("test failed");
      $fatal(1, "bound protocol checker reported an error");
    end else begin
      $display("test passed");
      $finish;
    end
  end

endmodule

//--- vlog.f
conv_code_pkg.sv
ctrl_pkg.sv
conv_cfg_regs.sv
conv_encoder.sv
puncturer.sv
symbol_mapper.sv
conv_qpsk_top.sv
conv_qpsk_chk.sv
conv_qpsk_tb.sv

//--- Bender.yml
package:
  name: conv_qpsk

sources:
  - files:
      - conv_code_pkg.sv
      - ctrl_pkg.sv
      - conv_cfg_regs.sv
      - conv_encoder.sv
      - puncturer.sv
      - symbol_mapper.sv
      - conv_qpsk_top.sv
  - target: test
    files:
      - conv_qpsk_chk.sv
      - conv_qpsk_tb.sv
